// File: isaPkg.sv
package isaPkg;

  // ==============================
  // Instruction word
  // ==============================
  typedef logic [31:0] instr_t;   // One ARM instruction
  typedef logic [3:0]  cond_t;    // Condition field, bits 31:28

  // Single-bit field positions
  localparam int bitImm     = 25;   // I bit of DP and LDR/STR
  localparam int bitUp      = 23;   // U bit, add offset when high
  localparam int bitByte    = 22;   // B bit of LDR/STR
  localparam int bitHalfImm = 22;   // Immediate offset form of LDRH/STRH
  localparam int bitLoad    = 20;   // L bit
  localparam int bitSet     = 20;   // S bit of DP

  localparam logic [3:0] halfPattern = 4'b1011;  // Bits 7:4 of unsigned halfword

  // ==============================
  // Condition codes
  // ==============================
  localparam cond_t condEq = 4'h0;
  localparam cond_t condNe = 4'h1;
  localparam cond_t condCs = 4'h2;
  localparam cond_t condCc = 4'h3;
  localparam cond_t condMi = 4'h4;
  localparam cond_t condPl = 4'h5;
  localparam cond_t condVs = 4'h6;
  localparam cond_t condVc = 4'h7;
  localparam cond_t condHi = 4'h8;
  localparam cond_t condLs = 4'h9;
  localparam cond_t condGe = 4'hA;
  localparam cond_t condLt = 4'hB;
  localparam cond_t condGt = 4'hC;
  localparam cond_t condLe = 4'hD;
  localparam cond_t condAl = 4'hE;

  // Instruction class, bits 27:26
  localparam logic [1:0] opDataProc  = 2'b00;
  localparam logic [1:0] opLoadStore = 2'b01;
  localparam logic [1:0] opBranch    = 2'b10;

endpackage

// File: ctrlPkg.sv
package ctrlPkg;

  // ==============================
  // ALU control and flags
  // ==============================
  typedef logic [3:0] aluCtrl_t;            // Same code as the DP opcode
  localparam aluCtrl_t aluAdd = 4'b0100;    // ADD opcode
  localparam aluCtrl_t aluSub = 4'b0010;    // SUB opcode

  typedef logic [3:0] flags_t;              // {N, Z, C, V}
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // Upper bit enables N and Z, lower bit enables C and V
  typedef logic [1:0] flagWrite_t;

  // ==============================
  // Memory lanes and selects
  // ==============================
  typedef logic [3:0] byteMask_t;           // One enable per byte lane
  typedef logic [1:0] byteOffset_t;         // Address bits 1:0

  // Bit 0 reads PC as Rn, bit 1 reads Rd as the store source
  typedef logic [1:0] regSrc_t;

  // 00 DP rotate imm, 01 12-bit offset, 10 branch offset, 11 split halfword offset
  typedef logic [1:0] immSrc_t;

endpackage

// File: ctrlIf.sv
`timescale 1ns/1ps

// Decoded control word from Decode into Execute
interface decodeIf;
  import isaPkg::*;
  import ctrlPkg::*;

  logic       regWrite;     // Writes Rd
  logic       memWrite;     // Store
  logic       memtoReg;     // Result comes from memory
  logic       branch;       // B instruction
  logic       pcSrc;        // Writes the PC
  logic       aluSrc;       // Immediate operand B
  aluCtrl_t   aluControl;
  flagWrite_t flagWrite;
  cond_t      cond;
  logic       byteAccess;   // LDRB/STRB
  logic       halfAccess;   // LDRH/STRH
  logic       loadFlag;     // Any load

  modport source (output regWrite, memWrite, memtoReg, branch, pcSrc, aluSrc,
                  aluControl, flagWrite, cond, byteAccess, halfAccess, loadFlag);
  modport sink   (input  regWrite, memWrite, memtoReg, branch, pcSrc, aluSrc,
                  aluControl, flagWrite, cond, byteAccess, halfAccess, loadFlag);
endinterface

// Condition-gated controls from Execute into Memory
interface retireIf;
  import ctrlPkg::*;

  logic        regWrite;
  logic        memWrite;
  logic        memtoReg;
  logic        pcSrc;
  logic        setFlags;    // Instruction updates NZCV
  flags_t      flagsNext;   // Merged flags after this instruction
  byteMask_t   byteMask;    // Lane enables, zero when no access
  byteOffset_t byteOffset;

  modport source (output regWrite, memWrite, memtoReg, pcSrc, setFlags,
                  flagsNext, byteMask, byteOffset);
  modport sink   (input  regWrite, memWrite, memtoReg, pcSrc, setFlags,
                  flagsNext, byteMask, byteOffset);
endinterface

// File: condUnit.sv
`timescale 1ns/1ps

module condUnit (
  input  isaPkg::cond_t       cond,       // Condition field in Execute
  input  ctrlPkg::flags_t     flags,      // Forwarded NZCV
  input  ctrlPkg::flags_t     aluFlags,   // Flags from this ALU result
  input  ctrlPkg::flagWrite_t flagWrite,
  output logic                condEx,     // Condition passed
  output ctrlPkg::flags_t     flagsNext
);
  import isaPkg::*;
  import ctrlPkg::*;

  logic n, z, c, v;

  assign {n, z, c, v} = {flags[flagN], flags[flagZ], flags[flagC], flags[flagV]};

  always_comb begin
    case (cond)
      condEq:  condEx = z;
      condNe:  condEx = ~z;
      condCs:  condEx = c;
      condCc:  condEx = ~c;
      condMi:  condEx = n;
      condPl:  condEx = ~n;
      condVs:  condEx = v;
      condVc:  condEx = ~v;
      condHi:  condEx = c & ~z;           // Unsigned higher
      condLs:  condEx = ~c | z;
      condGe:  condEx = (n == v);         // Signed compare
      condLt:  condEx = (n != v);
      condGt:  condEx = ~z & (n == v);
      condLe:  condEx = z | (n != v);
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;             // 1111 space never runs here
    endcase
  end

  // Merge N/Z and C/V independently
  assign flagsNext[3:2] = (flagWrite[1] && condEx) ? aluFlags[3:2] : flags[3:2];
  assign flagsNext[1:0] = (flagWrite[0] && condEx) ? aluFlags[1:0] : flags[1:0];

endmodule

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  isaPkg::instr_t   instrD,    // Instruction in Decode
  output ctrlPkg::regSrc_t regSrcD,   // Register-port selects
  output ctrlPkg::immSrc_t immSrcD,   // Immediate format
  decodeIf.source          dec        // Control word towards Execute
);
  import isaPkg::*;
  import ctrlPkg::*;

  logic [1:0] opClass;    // Bits 27:26
  logic       halfD;      // LDRH/STRH encoding
  logic       aluOpD;     // Data processing
  logic       ldStOpD;    // Any load or store
  logic       testOpD;    // TST TEQ CMP CMN
  logic       arithOpD;   // Opcode that yields C and V

  assign opClass  = instrD[27:26];
  assign halfD    = (instrD[27:25] == 3'b000) && (instrD[7:4] == halfPattern);
  assign testOpD  = (instrD[24:23] == 2'b10);
  assign arithOpD = (instrD[24:23] == 2'b01) || (instrD[24:22] == 3'b001)
                 || (instrD[24:22] == 3'b101);   // SUB..RSC, CMP, CMN

  // ==============================
  // Main decoder
  // ==============================
  always_comb begin
    regSrcD      = '0;     // Unsupported class stays all zero
    immSrcD      = '0;
    dec.aluSrc   = 1'b0;
    dec.memtoReg = 1'b0;
    dec.regWrite = 1'b0;
    dec.memWrite = 1'b0;
    dec.branch   = 1'b0;
    aluOpD       = 1'b0;
    ldStOpD      = 1'b0;
    case (opClass)
      opDataProc: begin
        if (halfD) begin
          ldStOpD    = 1'b1;
          immSrcD    = 2'b11;                     // imm8 split over 11:8 and 3:0
          dec.aluSrc = instrD[bitHalfImm];
        end else begin
          aluOpD       = 1'b1;
          dec.aluSrc   = instrD[bitImm];
          dec.regWrite = ~testOpD;                // Compares only set flags
        end
      end
      opLoadStore: begin
        ldStOpD    = 1'b1;
        immSrcD    = 2'b01;
        dec.aluSrc = ~instrD[bitImm];             // I bit inverted for LDR/STR
      end
      opBranch: begin
        if (instrD[bitImm]) begin                 // 101 is B, 100 is LDM/STM
          regSrcD    = 2'b01;                     // PC as base
          immSrcD    = 2'b10;
          dec.aluSrc = 1'b1;
          dec.branch = 1'b1;
        end
      end
      default: ;
    endcase
    if (ldStOpD) begin
      if (instrD[bitLoad]) begin
        dec.memtoReg = 1'b1;
        dec.regWrite = 1'b1;
      end else begin
        regSrcD[1]   = 1'b1;                      // Rd read as store data
        dec.memWrite = 1'b1;
      end
    end
  end

  // ==============================
  // ALU control
  // ==============================
  always_comb begin
    if (ldStOpD) begin
      dec.aluControl = instrD[bitUp] ? aluAdd : aluSub;   // Offset direction
      dec.flagWrite  = '0;
    end else if (aluOpD) begin
      dec.aluControl = instrD[24:21];
      dec.flagWrite  = {instrD[bitSet], instrD[bitSet] & arithOpD};
    end else begin
      dec.aluControl = dec.branch ? aluAdd : '0;         // PC plus offset
      dec.flagWrite  = '0;
    end
  end

  assign dec.pcSrc      = dec.branch
                       || (aluOpD && dec.regWrite && (instrD[15:12] == 4'hF));  // Rd is R15
  assign dec.cond       = instrD[31:28];
  assign dec.byteAccess = ldStOpD && (opClass == opLoadStore) && instrD[bitByte];
  assign dec.halfAccess = halfD;
  assign dec.loadFlag   = ldStOpD && instrD[bitLoad];

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stallE,
  input  logic                 flushE,
  decodeIf.sink                dec,
  input  ctrlPkg::flags_t      aluFlagsE,      // Raw ALU flags
  input  ctrlPkg::byteOffset_t addrLowE,       // ALU result bits 1:0
  input  ctrlPkg::flags_t      flagsE,         // Forwarded from retireStage
  output ctrlPkg::aluCtrl_t    aluControlE,
  output logic                 aluSrcE,
  output logic                 branchTakenE,
  retireIf.source              ret
);
  import isaPkg::*;
  import ctrlPkg::*;

  logic       regWriteE, memWriteE, memtoRegE, branchE, pcSrcE;
  logic       byteAccessE, halfAccessE, loadFlagE;
  flagWrite_t flagWriteE;
  cond_t      condE;
  logic       condEx;
  byteMask_t  laneMask;       // Mask before gating

  // ==============================
  // Execute register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin               // Flush wins over stall
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memtoRegE   <= 1'b0;
      branchE     <= 1'b0;
      pcSrcE      <= 1'b0;
      aluSrcE     <= 1'b0;
      aluControlE <= '0;
      flagWriteE  <= '0;
      condE       <= '0;
      byteAccessE <= 1'b0;
      halfAccessE <= 1'b0;
      loadFlagE   <= 1'b0;
    end else if (!stallE) begin
      regWriteE   <= dec.regWrite;
      memWriteE   <= dec.memWrite;
      memtoRegE   <= dec.memtoReg;
      branchE     <= dec.branch;
      pcSrcE      <= dec.pcSrc;
      aluSrcE     <= dec.aluSrc;
      aluControlE <= dec.aluControl;
      flagWriteE  <= dec.flagWrite;
      condE       <= dec.cond;
      byteAccessE <= dec.byteAccess;
      halfAccessE <= dec.halfAccess;
      loadFlagE   <= dec.loadFlag;
    end
  end

  condUnit cond_i (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (flagWriteE),
    .condEx    (condEx),
    .flagsNext (ret.flagsNext)
  );

  // Little-endian lane select
  always_comb begin
    if (halfAccessE)      laneMask = addrLowE[1] ? 4'b1100 : 4'b0011;
    else if (byteAccessE) laneMask = 4'b0001 << addrLowE;
    else                  laneMask = 4'b1111;          // Word
  end

  // ==============================
  // Condition gating
  // ==============================
  assign branchTakenE   = branchE & condEx;
  assign ret.regWrite   = regWriteE & condEx;
  assign ret.memWrite   = memWriteE & condEx;
  assign ret.memtoReg   = memtoRegE & condEx;    // No read when skipped
  assign ret.pcSrc      = pcSrcE & condEx;
  assign ret.setFlags   = (flagWriteE != 2'b00) & condEx;
  assign ret.byteMask   = ((memWriteE || loadFlagE) && condEx) ? laneMask : '0;
  assign ret.byteOffset = addrLowE;

endmodule

// File: retireStage.sv
`timescale 1ns/1ps

module retireStage (
  input  logic               clk,
  input  logic               reset,
  input  logic               stallM,
  input  logic               flushM,
  input  logic               stallW,
  input  logic               flushW,
  retireIf.sink              ret,
  output logic               memWriteM,
  output logic               memtoRegM,
  output ctrlPkg::byteMask_t byteMaskM,
  output logic               regWriteM,
  output logic               regWriteW,
  output logic               memtoRegW,
  output logic               pcSrcW,
  output ctrlPkg::flags_t    flagsE        // Newest flags for Execute
);
  import ctrlPkg::*;

  logic   pcSrcM, setFlagsM, setFlagsW;
  flags_t flagsNextM, flagsNextW;
  flags_t flagsReg;                        // Architectural NZCV

  // ==============================
  // Memory register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset || flushM) begin
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
      setFlagsM <= 1'b0;
      byteMaskM <= '0;
    end else if (!stallM) begin
      memWriteM <= ret.memWrite;
      memtoRegM <= ret.memtoReg;
      regWriteM <= ret.regWrite;
      pcSrcM    <= ret.pcSrc;
      setFlagsM <= ret.setFlags;
      byteMaskM <= ret.byteMask;
    end
  end

  always_ff @(posedge clk) if (!stallM) flagsNextM <= ret.flagsNext;

  // ==============================
  // Writeback register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
    end else if (!stallW) begin
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
      setFlagsW <= setFlagsM;
    end
  end

  always_ff @(posedge clk) if (!stallW) flagsNextW <= flagsNextM;

  // Flags commit as Writeback ends
  always_ff @(posedge clk) begin
    if (reset)                      flagsReg <= '0;
    else if (setFlagsW && !stallW)  flagsReg <= flagsNextW;
  end

  // Memory result is newer than Writeback
  assign flagsE = setFlagsM ? flagsNextM : (setFlagsW ? flagsNextW : flagsReg);

endmodule

// File: armController.sv
`timescale 1ns/1ps

module armController (
  input  logic                 clk,
  input  logic                 reset,
  input  isaPkg::instr_t       instrD,
  input  ctrlPkg::flags_t      aluFlagsE,
  input  ctrlPkg::byteOffset_t addrLowE,
  input  logic                 stallE,
  input  logic                 flushE,
  input  logic                 stallM,
  input  logic                 flushM,
  input  logic                 stallW,
  input  logic                 flushW,
  output ctrlPkg::regSrc_t     regSrcD,
  output ctrlPkg::immSrc_t     immSrcD,
  output ctrlPkg::aluCtrl_t    aluControlE,
  output logic                 aluSrcE,
  output logic                 branchTakenE,
  output logic                 memWriteM,
  output logic                 memtoRegM,
  output ctrlPkg::byteMask_t   byteMaskM,
  output logic                 regWriteM,
  output logic                 regWriteW,
  output logic                 memtoRegW,
  output logic                 pcSrcW,
  output ctrlPkg::flags_t      flagsE
);

  decodeIf decBus ();    // Decode to Execute
  retireIf retBus ();    // Execute to Memory

  instrDecoder decoder_i (.instrD(instrD), .regSrcD(regSrcD), .immSrcD(immSrcD), .dec(decBus));

  executeStage execute_i (
    .clk(clk), .reset(reset), .stallE(stallE), .flushE(flushE),
    .dec(decBus), .aluFlagsE(aluFlagsE), .addrLowE(addrLowE), .flagsE(flagsE),
    .aluControlE(aluControlE), .aluSrcE(aluSrcE), .branchTakenE(branchTakenE),
    .ret(retBus)
  );

  retireStage retire_i (
    .clk(clk), .reset(reset), .stallM(stallM), .flushM(flushM),
    .stallW(stallW), .flushW(flushW), .ret(retBus),
    .memWriteM(memWriteM), .memtoRegM(memtoRegM), .byteMaskM(byteMaskM),
    .regWriteM(regWriteM), .regWriteW(regWriteW), .memtoRegW(memtoRegW),
    .pcSrcW(pcSrcW), .flagsE(flagsE)
  );

endmodule

// File: armController_assert.sv
`timescale 1ns/1ps

module armController_assert (
  input logic               clk,
  input logic               reset,
  input logic               flushE,
  input ctrlPkg::aluCtrl_t  aluControlE,
  input logic               aluSrcE,
  input logic               branchTakenE,
  input logic               memWriteM,
  input logic               memtoRegM,
  input ctrlPkg::byteMask_t byteMaskM,
  input logic               regWriteM,
  input logic               regWriteW,
  input logic               memtoRegW,
  input logic               pcSrcW
);

  int failCount = 0;    // Failed assertions so far

  // A store always enables some lane
  storeMask: assert property (@(posedge clk) disable iff (reset) memWriteM |-> byteMaskM != 0)
    else begin
      $error("Store with empty byte mask");
      failCount++;
    end

  // Reset values still visible on the release edge
  resetIdle: assert property (@(posedge clk) $fell(reset) |->
      !(aluSrcE || branchTakenE || memWriteM || memtoRegM || regWriteM || regWriteW
        || memtoRegW || pcSrcW) && aluControlE == 0 && byteMaskM == 0)
    else begin
      $error("Control output active right after reset");
      failCount++;
    end

  // Bubble reaches Memory two edges on
  flushBubble: assert property (@(posedge clk) disable iff (reset) flushE |-> ##2 !regWriteM)
    else begin
      $error("Flushed slot wrote a register");
      failCount++;
    end

endmodule

bind armController armController_assert assert_i (.*);

// File: armController_tb.sv
`timescale 1ns/1ps

module armController_tb;
  import isaPkg::*;

  localparam logic [31:0] nopInstr = 32'hEC00_0000;   // Class 11, decodes to all zero
  localparam int randCount = 40;

  // One stimulus row with the outputs it should produce
  typedef struct packed {
    logic [31:0] instr;
    logic [3:0]  aluFlags;
    logic [1:0]  addrLow;
    logic        stall, flush, useModel;
    logic [3:0]  alu;
    logic        aluSrc, br, memW, mtr;
    logic [3:0]  mask;
    logic        regW, pc;
  } row_t;

  // Expected outputs of one instruction as it moves down the pipe
  typedef struct packed {
    logic [3:0] alu;
    logic       aluSrc, br, memW, mtr;
    logic [3:0] mask;
    logic       regW, pc, setFl;
    logic [3:0] flNext;
  } expect_t;

  logic clk, reset, stallE, flushE, stallM, flushM, stallW, flushW;
  logic [31:0] instrD;
  logic [3:0] aluFlagsE, aluControlE, byteMaskM, flagsE;
  logic [1:0] addrLowE, regSrcD, immSrcD;
  logic aluSrcE, branchTakenE, memWriteM, memtoRegM, regWriteM;
  logic regWriteW, memtoRegW, pcSrcW;

  row_t    rows[$];
  expect_t eExp, mExp, wExp;
  logic [3:0] modelFlags;     // NZCV as Execute should see them
  int exIdx, errors, checks;
  bit rowsReady;

  armController dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;    // 4 ns period
  end

  // ==============================
  // Encoders and reference model
  // ==============================
  function automatic logic [31:0] dp(logic [3:0] c, logic i, logic [3:0] op, logic s,
                                     logic [3:0] rd);
    return {c, 2'b00, i, op, s, 4'h1, rd, 12'h002};
  endfunction

  function automatic logic [31:0] ls(logic [3:0] c, logic l, logic u, logic b);
    return {c, 2'b01, 1'b0, 1'b1, u, b, 1'b0, l, 4'h2, 4'h3, 12'h004};   // Imm offset
  endfunction

  function automatic logic [31:0] half(logic [3:0] c, logic l, logic u);
    return {c, 3'b000, 1'b1, u, 1'b1, 1'b0, l, 4'h2, 4'h3, 4'h0, 4'b1011, 4'h4};
  endfunction

  function automatic logic [31:0] br(logic [3:0] c);
    return {c, 3'b101, 1'b0, 24'h000010};
  endfunction

  // {regSrc, immSrc} by instruction class
  function automatic logic [3:0] decodeSelects(logic [31:0] in);
    logic store;
    store = !in[20];                                  // L bit low
    if (in[27:25] == 3'b101) return 4'b0110;          // B reads PC, 24-bit offset
    if (in[27:26] == 2'b01) return {store, 3'b001};   // LDR/STR, 12-bit offset
    if (in[27:25] == 3'b000 && in[7:4] == 4'b1011)
      return {store, 3'b011};                         // LDRH/STRH, split offset
    return 4'h0;                                      // DP and no-op
  endfunction

  // ARM condition rules on {N, Z, C, V}
  function automatic logic condPass(logic [3:0] c, logic [3:0] f);
    case (c)
      4'h0: return f[2];
      4'h1: return !f[2];
      4'h2: return f[1];
      4'h3: return !f[1];
      4'h4: return f[3];
      4'h5: return !f[3];
      4'h6: return f[0];
      4'h7: return !f[0];
      4'h8: return f[1] && !f[2];
      4'h9: return !f[1] || f[2];
      4'hA: return f[3] == f[0];
      4'hB: return f[3] != f[0];
      4'hC: return !f[2] && (f[3] == f[0]);
      4'hD: return f[2] || (f[3] != f[0]);
      4'hE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic expect_t expectFor(row_t r, logic [3:0] fl);
    expect_t e;
    logic pass, isDp, s;
    logic [3:0] op;
    op   = r.instr[24:21];
    pass = condPass(r.instr[31:28], fl);
    isDp = (r.instr[27:26] == 2'b00) && (r.instr[7:4] != 4'b1011);
    s    = isDp && r.instr[20] && pass;
    e    = '0;
    if (r.useModel) begin
      e.alu    = op;
      e.aluSrc = r.instr[25];
      e.regW   = (op[3:2] != 2'b10) && pass;              // Compares write no register
      e.pc     = e.regW && (r.instr[15:12] == 4'hF);
    end else begin
      {e.alu, e.aluSrc, e.br, e.memW, e.mtr} = {r.alu, r.aluSrc, r.br, r.memW, r.mtr};
      {e.mask, e.regW, e.pc} = {r.mask, r.regW, r.pc};
    end
    e.setFl  = s;
    e.flNext = fl;
    if (s) e.flNext[3:2] = r.aluFlags[3:2];
    if (s && (op inside {[4'h2:4'h7], 4'hA, 4'hB})) e.flNext[1:0] = r.aluFlags[1:0];
    return e;
  endfunction

  task automatic addRow(logic [31:0] in, logic [3:0] fl, logic [1:0] a, logic st, logic fh,
                        logic [3:0] alu, logic src, logic b, logic mw, logic mr,
                        logic [3:0] mk, logic rw, logic pc);
    rows.push_back({in, fl, a, st, fh, 1'b0, alu, src, b, mw, mr, mk, rw, pc});
  endtask

  task automatic checkValue(string name, logic [7:0] got, logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ==============================
  // Stimulus and checks
  // ==============================
  initial begin
    logic [31:0] in;
    logic [3:0]  selExp;
    reset = 1'b1;
    instrD = nopInstr;
    {aluFlagsE, addrLowE, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    {errors, checks, exIdx} = {32'd0, 32'd0, -32'sd1};
    {eExp, mExp, wExp, modelFlags} = '0;
    void'($urandom(32'h263d));
    //     instr                     flags  addr st fl alu src br mw mr mask rw pc
    addRow(dp(condAl, 0, 4'h4, 0, 1), 4'h0, 0, 0, 0, 4'h4, 0, 0, 0, 0, 4'h0, 1, 0);
    addRow(dp(condAl, 1, 4'hC, 0, 2), 4'h0, 0, 0, 0, 4'hC, 1, 0, 0, 0, 4'h0, 1, 0);
    addRow(dp(condAl, 0, 4'hA, 1, 0), 4'h4, 0, 0, 0, 4'hA, 0, 0, 0, 0, 4'h0, 0, 0);  // CMP, Z
    addRow(dp(condEq, 0, 4'h4, 0, 1), 4'h0, 0, 0, 0, 4'h4, 0, 0, 0, 0, 4'h0, 1, 0);
    addRow(dp(condNe, 0, 4'h4, 0, 1), 4'h0, 0, 0, 0, 4'h4, 0, 0, 0, 0, 4'h0, 0, 0);
    addRow(br(condEq),                4'h0, 0, 0, 0, 4'h4, 1, 1, 0, 0, 4'h0, 0, 1);
    addRow(br(condNe),                4'h0, 0, 0, 0, 4'h4, 1, 0, 0, 0, 4'h0, 0, 0);
    addRow(dp(condAl, 0, 4'hA, 1, 0), 4'h8, 0, 0, 0, 4'hA, 0, 0, 0, 0, 4'h0, 0, 0);  // N, no V
    addRow(dp(condGe, 0, 4'h4, 0, 1), 4'h0, 0, 0, 0, 4'h4, 0, 0, 0, 0, 4'h0, 0, 0);
    addRow(dp(condLt, 0, 4'h4, 0, 1), 4'h0, 0, 0, 0, 4'h4, 0, 0, 0, 0, 4'h0, 1, 0);
    addRow(dp(condAl, 0, 4'hA, 1, 0), 4'h2, 0, 0, 0, 4'hA, 0, 0, 0, 0, 4'h0, 0, 0);  // C only
    addRow(dp(condHi, 0, 4'h4, 0, 1), 4'h0, 0, 0, 0, 4'h4, 0, 0, 0, 0, 4'h0, 1, 0);
    addRow(dp(condLs, 0, 4'h4, 0, 1), 4'h0, 0, 0, 0, 4'h4, 0, 0, 0, 0, 4'h0, 0, 0);
    addRow(ls(condAl, 0, 1, 0),       4'h0, 0, 0, 0, 4'h4, 1, 0, 1, 0, 4'hF, 0, 0);  // STR
    for (int k = 0; k < 4; k++)                                                      // STRB
      addRow(ls(condAl, 0, 0, 1), 4'h0, 2'(k), 0, 0, 4'h2, 1, 0, 1, 0, 4'h1 << k, 0, 0);
    addRow(half(condAl, 0, 1),        4'h0, 0, 0, 0, 4'h4, 1, 0, 1, 0, 4'h3, 0, 0);  // STRH
    addRow(half(condAl, 0, 1),        4'h0, 2, 0, 0, 4'h4, 1, 0, 1, 0, 4'hC, 0, 0);
    addRow(ls(condAl, 1, 1, 0),       4'h0, 1, 0, 0, 4'h4, 1, 0, 0, 1, 4'hF, 1, 0);  // LDR
    addRow(ls(condAl, 1, 0, 1),       4'h0, 3, 0, 0, 4'h2, 1, 0, 0, 1, 4'h8, 1, 0);  // LDRB
    addRow(dp(condAl, 0, 4'h4, 0, 1), 4'h0, 0, 0, 1, 4'h0, 0, 0, 0, 0, 4'h0, 0, 0);  // Flushed
    addRow(dp(condAl, 1, 4'hC, 0, 2), 4'h0, 0, 0, 0, 4'hC, 1, 0, 0, 0, 4'h0, 1, 0);
    addRow(dp(condAl, 0, 4'h4, 0, 1), 4'h0, 0, 1, 0, 4'hC, 1, 0, 0, 0, 4'h0, 1, 0);  // Held
    addRow(dp(condAl, 0, 4'h4, 0, 1), 4'h0, 0, 1, 0, 4'hC, 1, 0, 0, 0, 4'h0, 1, 0);
    addRow(dp(condAl, 0, 4'h0, 0, 3), 4'h0, 0, 0, 0, 4'h0, 0, 0, 0, 0, 4'h0, 1, 0);
    for (int k = 0; k < randCount; k++) begin     // Random DP tail, model checked
      in = dp(4'($urandom % 15), 1'($urandom), 4'($urandom), 1'($urandom), 4'($urandom));
      rows.push_back({in, 4'($urandom), 2'($urandom), 3'b001, 14'h0});
    end
    repeat (4) addRow(nopInstr, 4'h0, 0, 0, 0, 4'h0, 0, 0, 0, 0, 4'h0, 0, 0);  // Drain
    rowsReady = 1'b1;

    repeat (10) @(posedge clk);
    reset  <= 1'b0;
    instrD <= rows[0].instr;
    {stallE, flushE} <= {rows[0].stall, rows[0].flush};
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      wExp = mExp;                                      // Pipeline model advances
      if (eExp.setFl) modelFlags = eExp.flNext;
      mExp = eExp;
      if (rows[i].flush)       exIdx = -1;              // Bubble
      else if (!rows[i].stall) exIdx = i;
      eExp = (exIdx < 0) ? '0 : expectFor(rows[exIdx], modelFlags);
      aluFlagsE <= (exIdx < 0) ? 4'h0 : rows[exIdx].aluFlags;
      addrLowE  <= (exIdx < 0) ? 2'd0 : rows[exIdx].addrLow;
      in = (i + 1 < rows.size()) ? rows[i + 1].instr : nopInstr;
      selExp = decodeSelects(in);
      instrD <= in;
      stallE <= (i + 1 < rows.size()) && rows[i + 1].stall;
      flushE <= (i + 1 < rows.size()) && rows[i + 1].flush;
      @(negedge clk);                                   // Outputs settled here
      checkValue("regSrcD", 8'(regSrcD), 8'(selExp[3:2]));
      checkValue("immSrcD", 8'(immSrcD), 8'(selExp[1:0]));
      checkValue("aluControlE", 8'(aluControlE), 8'(eExp.alu));
      checkValue("aluSrcE", 8'(aluSrcE), 8'(eExp.aluSrc));
      checkValue("branchTakenE", 8'(branchTakenE), 8'(eExp.br));
      checkValue("memWriteM", 8'(memWriteM), 8'(mExp.memW));
      checkValue("memtoRegM", 8'(memtoRegM), 8'(mExp.mtr));
      checkValue("byteMaskM", 8'(byteMaskM), 8'(mExp.mask));
      checkValue("regWriteM", 8'(regWriteM), 8'(mExp.regW));
      checkValue("regWriteW", 8'(regWriteW), 8'(wExp.regW));
      checkValue("memtoRegW", 8'(memtoRegW), 8'(wExp.mtr));
      checkValue("pcSrcW", 8'(pcSrcW), 8'(wExp.pc));
      checkValue("flagsE", 8'(flagsE), 8'(modelFlags));
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut_i.assert_i.failCount);
    if (errors == 0 && dut_i.assert_i.failCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // Watchdog, rows plus reset and margin
  initial begin
    wait (rowsReady);
    #((rows.size() + 40) * 4);
    $display("Timeout: the pipeline run did not reach its end in time");
    $display("Verification failed");
    $finish;
  end

endmodule

// File: build.f
isaPkg.sv
ctrlPkg.sv
ctrlIf.sv
condUnit.sv
instrDecoder.sv
executeStage.sv
retireStage.sv
armController.sv
armController_assert.sv
armController_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLIST     ?= build.f
TOP       ?= armController_tb
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)
